// File: hw/vxe_vpu_us_pkg.sv
/*
 * Shared definitions of the VPU upstream request path
 * Address word is txnid on top, then the read flag, then 37 address bits
 * Transaction id is client on top, then thread id, then the argument bit
 * Queue depth must stay a power of two since pointers carry one wrap bit
 */

package vxe_vpu_us_pkg;

/* ============================== */
/* Word widths                    */
/* ============================== */
localparam int RQA_W	= 44;	/* Address/command word */
localparam int RQD_W	= 72;	/* Write data word */
localparam int TXNID_W	= 6;	/* Transaction id */
localparam int ADDR_W	= 37;	/* Upper bits of the 40-bit address */
localparam int CLIENT_W	= 2;	/* Client id inside the txnid */
localparam int THREAD_W	= 3;	/* Thread id inside the txnid */

/* ============================== */
/* Field positions                */
/* ============================== */
/* Address word */
localparam int RQA_TXNID_LSB	= RQA_W - TXNID_W;	/* Txnid sits in the top bits */
localparam int RQA_RNW_BIT	= ADDR_W;		/* Set for a read request */
localparam int RQA_ADDR_LSB	= 0;			/* Address fills the low bits */

/* Transaction id */
localparam int TXN_CLIENT_LSB	= TXNID_W - CLIENT_W;	/* Client on top */
localparam int TXN_THREAD_LSB	= 1;			/* Thread between client and arg */
localparam int TXN_ARG_BIT	= 0;			/* Argument type (Rs/Rt) */

/* Client codes */
localparam logic [CLIENT_W-1:0] CLNT_VPU0 = 2'd0;
localparam logic [CLIENT_W-1:0] CLNT_VPU1 = 2'd1;

/* ============================== */
/* Queues and state machines      */
/* ============================== */
localparam int Q_DEPTH	= 4;	/* Entries per queue */
localparam int Q_PTR_W	= 3;	/* Index bits plus the wrap bit */

/* Ingress FSM states */
localparam logic [1:0] FSM_RX_IDLE = 2'b00;	/* Out of reset */
localparam logic [1:0] FSM_RX_RDAD = 2'b01;	/* Taking address and data */
localparam logic [1:0] FSM_RX_RDAX = 2'b10;	/* Taking address only, data held */
localparam logic [1:0] FSM_RX_STLL = 2'b11;	/* Waiting for queue room */

/* Queue transmit FSM states */
localparam logic FSM_TX_IDLE = 1'b0;	/* Nothing on the port */
localparam logic FSM_TX_SEND = 1'b1;	/* Word offered with wr high */

/* Payload types */
typedef logic [RQA_W-1:0] rqa_t;	/* Address/command word */
typedef logic [RQD_W-1:0] rqd_t;	/* Data word */

endpackage

// File: hw/vxe_vpu_us_decode.sv
`timescale 1ns/100ps

/*
 * Address word decoder with the routing rule
 * Purely combinational, fields are valid whenever i_rqa is
 * Reads follow the argument bit, writes follow the client
 */

module vxe_vpu_us_decode
	import vxe_vpu_us_pkg::*;
(
	input  rqa_t			i_rqa,		/* Address/command word */
	output logic [TXNID_W-1:0]	o_txnid,	/* Transaction id */
	output logic			o_rnw,		/* 1 for read, 0 for write */
	output logic [ADDR_W-1:0]	o_addr,		/* Upper address bits */
	output logic [CLIENT_W-1:0]	o_client_id,	/* VPU0 or VPU1 */
	output logic [THREAD_W-1:0]	o_thread_id,	/* VPU thread (0-7) */
	output logic			o_argument,	/* Argument type */
	output logic			o_mport		/* Destination master */
);

/* Destination master for one request */
function automatic logic get_mport(
	input logic			rnw,
	input logic			arg,
	input logic [CLIENT_W-1:0]	client
);
	/* Loads go by argument type so Rs and Rt fetch in parallel */
	if(rnw)
		return arg;
	/* Stores go by VPU, anything that is not VPU0 lands on master 1 */
	return (client == CLNT_VPU0) ? 1'b0 : 1'b1;
endfunction

/* ============================== */
/* Field extraction               */
/* ============================== */
assign o_txnid = i_rqa[RQA_TXNID_LSB +: TXNID_W];
assign o_rnw = i_rqa[RQA_RNW_BIT];
assign o_addr = i_rqa[RQA_ADDR_LSB +: ADDR_W];

/* Txnid subfields */
assign o_client_id = o_txnid[TXN_CLIENT_LSB +: CLIENT_W];
assign o_thread_id = o_txnid[TXN_THREAD_LSB +: THREAD_W];
assign o_argument = o_txnid[TXN_ARG_BIT];

/* The one place the routing rule lives */
assign o_mport = get_mport(o_rnw, o_argument, o_client_id);

endmodule

// File: hw/vxe_vpu_us_rx.sv
`timescale 1ns/100ps

/*
 * Ingress stage of the VPU upstream path
 * Write data must be presented no later than its write address word
 * Early data is held in a single register, a second early word waits at
 * the source until the held one leaves with its write address
 * i_stall must include the nearly-full flags, which leaves room for the
 * one word that may still be taken on the edge where the stall is seen
 */

module vxe_vpu_us_rx
	import vxe_vpu_us_pkg::*;
(
	input  logic	clk,
	input  logic	nrst,
	/* Address channel */
	input  logic	i_rqa_vld,
	input  rqa_t	i_rqa,
	output logic	o_rqa_rd,
	/* Data channel */
	input  logic	i_rqd_vld,
	input  rqd_t	i_rqd,
	output logic	o_rqd_rd,
	/* From the decoder */
	input  logic	i_rnw,
	input  logic	i_mport,
	/* Queue side */
	input  logic	i_stall,	/* Some queue is full or nearly full */
	output logic	o_m0_rqa_push,
	output logic	o_m1_rqa_push,
	output logic	o_m0_rqd_push,
	output logic	o_m1_rqd_push,
	output rqa_t	o_rqa_word,
	output rqd_t	o_rqd_word
);

logic [1:0]	rx_state;	/* Current FSM state */
logic [1:0]	rcvr_state;	/* State to resume after a stall */
logic [1:0]	run_next;	/* Next running state ignoring stall */
rqd_t		data_q;		/* Early write data */
logic		rqa_take;	/* Address word consumed this edge */
logic		rqd_take;	/* Data word consumed this edge */
logic		hold_d;		/* Data consumed with no write to pair it */
logic		pair_q;		/* Held data leaves with this write */
logic		rqd_push;	/* Some data queue gets a word */

/* ============================== */
/* Handshake and steering         */
/* ============================== */
assign rqa_take = i_rqa_vld && o_rqa_rd;
assign rqd_take = i_rqd_vld && o_rqd_rd;

/* Data with a read address, or with no address at all, has to wait */
assign hold_d = (rx_state == FSM_RX_RDAD) && rqd_take && !(rqa_take && !i_rnw);
assign pair_q = (rx_state == FSM_RX_RDAX) && rqa_take && !i_rnw;

/* Data goes out either straight with its write or from the hold register */
assign rqd_push = ((rx_state == FSM_RX_RDAD) && rqd_take && rqa_take && !i_rnw) ||
	pair_q;

assign o_m0_rqa_push = rqa_take && !i_mport;
assign o_m1_rqa_push = rqa_take && i_mport;
assign o_m0_rqd_push = rqd_push && !i_mport;	/* Same master as the address */
assign o_m1_rqd_push = rqd_push && i_mport;

assign o_rqa_word = i_rqa;
assign o_rqd_word = (rx_state == FSM_RX_RDAX) ? data_q : i_rqd;

/* Running state that follows this edge when no stall hits */
always_comb
begin
	if(hold_d)
		run_next = FSM_RX_RDAX;
	else if(pair_q)
		run_next = FSM_RX_RDAD;
	else
		run_next = rx_state;
end

/* Hold register for early data */
always_ff @(posedge clk)
begin
	if(hold_d)
		data_q <= i_rqd;
end

/* ============================== */
/* Ingress FSM                    */
/* ============================== */
always_ff @(posedge clk or negedge nrst)
begin
	if(!nrst)
	begin
		rx_state <= FSM_RX_IDLE;
		rcvr_state <= FSM_RX_RDAD;
		o_rqa_rd <= 1'b0;
		o_rqd_rd <= 1'b0;
	end
	else
	begin
		case(rx_state)
		FSM_RX_IDLE:
		begin
			rx_state <= FSM_RX_RDAD;	/* Start reading right away */
			o_rqa_rd <= 1'b1;
			o_rqd_rd <= 1'b1;
		end
		FSM_RX_RDAD, FSM_RX_RDAX:
		begin
			if(i_stall)
			begin
				/* Park both channels and remember where to resume */
				rcvr_state <= run_next;
				rx_state <= FSM_RX_STLL;
				o_rqa_rd <= 1'b0;
				o_rqd_rd <= 1'b0;
			end
			else
			begin
				rx_state <= run_next;
				o_rqa_rd <= 1'b1;
				o_rqd_rd <= (run_next == FSM_RX_RDAD);	/* Data waits while one is held */
			end
		end
		default:
		begin
			if(!i_stall)
			begin
				rx_state <= rcvr_state;
				o_rqa_rd <= 1'b1;
				o_rqd_rd <= (rcvr_state == FSM_RX_RDAD);
			end
		end
		endcase
	end
end

/* ============================== */
/* Checks                         */
/* ============================== */
/* Held data must not be overwritten by a new data word */
a_rdax_no_rqd: assert property (@(posedge clk) disable iff (!nrst)
	(rx_state == FSM_RX_RDAX) |-> !o_rqd_rd);

/* Queue pressure closes both channels by the next cycle */
a_stall_closes: assert property (@(posedge clk) disable iff (!nrst)
	i_stall |=> (!o_rqa_rd && !o_rqd_rd));

endmodule

// File: hw/vxe_vpu_us_queue.sv
`timescale 1ns/100ps

/*
 * Four-entry queue feeding one write/ready master port
 * A word pushed at edge N shows on the port after edge N+1 at the earliest
 * Pushing while o_full is high is not allowed and is not guarded here
 * o_pre_full rises one entry before full so a pipelined writer can stop
 */

module vxe_vpu_us_queue
	import vxe_vpu_us_pkg::*;
#(
	parameter type payload_t = rqa_t	/* Word carried by this queue */
)
(
	input  logic		clk,
	input  logic		nrst,
	/* Push side */
	input  logic		i_push,
	input  payload_t	i_word,
	output logic		o_full,
	output logic		o_pre_full,
	/* Master port */
	input  logic		i_rdy,
	output payload_t	o_word,
	output logic		o_wr
);

payload_t		mem [Q_DEPTH];	/* Circular storage */
logic [Q_PTR_W-1:0]	wp;		/* Write pointer with wrap bit */
logic [Q_PTR_W-1:0]	rp;		/* Read pointer with wrap bit */
logic [Q_PTR_W-1:0]	q_count;	/* Words stored, not counting o_word */
logic			empty;
logic			tx_state;	/* Transmit FSM state */
logic			load;		/* Head moves into the output register */

/* ============================== */
/* Occupancy                      */
/* ============================== */
assign q_count = wp - rp;	/* Wrap bit makes this exact up to Q_DEPTH */
assign empty = (wp == rp);
assign o_full = (q_count == Q_PTR_W'(Q_DEPTH));
assign o_pre_full = (q_count == Q_PTR_W'(Q_DEPTH - 1));

/* Storage is written at the push edge itself */
always_ff @(posedge clk)
begin
	if(i_push)
		mem[wp[Q_PTR_W-2:0]] <= i_word;
end

always_ff @(posedge clk or negedge nrst)
begin
	if(!nrst)
		wp <= '0;
	else if(i_push)
		wp <= wp + Q_PTR_W'(1);
end

/* ============================== */
/* Transmit FSM                   */
/* ============================== */
/*
 * A new word is loaded when the port is free or when the master
 * accepts the current one in this same cycle
 */
assign load = !empty && ((tx_state == FSM_TX_IDLE) || i_rdy);
assign o_wr = (tx_state == FSM_TX_SEND);	/* Straight from the state flop */

always_ff @(posedge clk or negedge nrst)
begin
	if(!nrst)
	begin
		tx_state <= FSM_TX_IDLE;
		rp <= '0;
	end
	else
	begin
		if(load)
			rp <= rp + Q_PTR_W'(1);

		case(tx_state)
		FSM_TX_IDLE:
		begin
			if(!empty)
				tx_state <= FSM_TX_SEND;
		end
		FSM_TX_SEND:
		begin
			/* Drop wr only once the last word is accepted */
			if(i_rdy && empty)
				tx_state <= FSM_TX_IDLE;
		end
		endcase
	end
end

/* Output word register */
always_ff @(posedge clk)
begin
	if(load)
		o_word <= mem[rp[Q_PTR_W-2:0]];
end

/* ============================== */
/* Checks                         */
/* ============================== */
/* An offered word stays put until the master takes it */
a_wr_hold: assert property (@(posedge clk) disable iff (!nrst)
	(o_wr && !i_rdy) |=> (o_wr && $stable(o_word)));

endmodule

// File: hw/vxe_mem_hub_vpu_us.sv
`timescale 1ns/100ps

/*
 * VPU upstream request path of the memory hub
 * Two upstream channels fan out to two masters through four queues
 * No ordering is kept between master 0 and master 1
 * Write data must not trail its write address at the input
 */

module vxe_mem_hub_vpu_us
	import vxe_vpu_us_pkg::*;
(
	input  logic	clk,
	input  logic	nrst,
	/* Incoming request */
	input  logic	i_rqa_vld,
	input  rqa_t	i_rqa,
	output logic	o_rqa_rd,
	input  logic	i_rqd_vld,
	input  rqd_t	i_rqd,
	output logic	o_rqd_rd,
	/* Route to master 0 */
	input  logic	i_m0_rqa_rdy,
	output rqa_t	o_m0_rqa,
	output logic	o_m0_rqa_wr,
	input  logic	i_m0_rqd_rdy,
	output rqd_t	o_m0_rqd,
	output logic	o_m0_rqd_wr,
	/* Route to master 1 */
	input  logic	i_m1_rqa_rdy,
	output rqa_t	o_m1_rqa,
	output logic	o_m1_rqa_wr,
	input  logic	i_m1_rqd_rdy,
	output rqd_t	o_m1_rqd,
	output logic	o_m1_rqd_wr
);

logic	rqa_rnw;	/* Current address is a read */
logic	rqa_mport;	/* Destination of the current address */
logic	stall;		/* Ingress must stop */
logic	m0_rqa_push, m1_rqa_push, m0_rqd_push, m1_rqd_push;
rqa_t	rqa_word;	/* Address word to push */
rqd_t	rqd_word;	/* Data word to push, live or held */
logic	m0_rqa_full, m1_rqa_full, m0_rqd_full, m1_rqd_full;
logic	m0_rqa_pre_full, m1_rqa_pre_full, m0_rqd_pre_full, m1_rqd_pre_full;

/* Any queue at three or four entries stops ingress */
assign stall = m0_rqa_full || m1_rqa_full || m0_rqd_full || m1_rqd_full ||
	m0_rqa_pre_full || m1_rqa_pre_full || m0_rqd_pre_full || m1_rqd_pre_full;

/* ============================== */
/* Decode and ingress             */
/* ============================== */
/* Only the read flag and the route are needed on this path */
vxe_vpu_us_decode decode_i (
	.i_rqa(i_rqa), .o_txnid(), .o_rnw(rqa_rnw), .o_addr(),
	.o_client_id(), .o_thread_id(), .o_argument(), .o_mport(rqa_mport)
);

vxe_vpu_us_rx rx_i (
	.clk(clk), .nrst(nrst),
	.i_rqa_vld(i_rqa_vld), .i_rqa(i_rqa), .o_rqa_rd(o_rqa_rd),
	.i_rqd_vld(i_rqd_vld), .i_rqd(i_rqd), .o_rqd_rd(o_rqd_rd),
	.i_rnw(rqa_rnw), .i_mport(rqa_mport), .i_stall(stall),
	.o_m0_rqa_push(m0_rqa_push), .o_m1_rqa_push(m1_rqa_push),
	.o_m0_rqd_push(m0_rqd_push), .o_m1_rqd_push(m1_rqd_push),
	.o_rqa_word(rqa_word), .o_rqd_word(rqd_word)
);

/* ============================== */
/* Per-master queues              */
/* ============================== */
vxe_vpu_us_queue #(.payload_t(rqa_t)) m0_rqa_q (
	.clk(clk), .nrst(nrst), .i_push(m0_rqa_push), .i_word(rqa_word),
	.o_full(m0_rqa_full), .o_pre_full(m0_rqa_pre_full),
	.i_rdy(i_m0_rqa_rdy), .o_word(o_m0_rqa), .o_wr(o_m0_rqa_wr)
);

vxe_vpu_us_queue #(.payload_t(rqa_t)) m1_rqa_q (
	.clk(clk), .nrst(nrst), .i_push(m1_rqa_push), .i_word(rqa_word),
	.o_full(m1_rqa_full), .o_pre_full(m1_rqa_pre_full),
	.i_rdy(i_m1_rqa_rdy), .o_word(o_m1_rqa), .o_wr(o_m1_rqa_wr)
);

vxe_vpu_us_queue #(.payload_t(rqd_t)) m0_rqd_q (
	.clk(clk), .nrst(nrst), .i_push(m0_rqd_push), .i_word(rqd_word),
	.o_full(m0_rqd_full), .o_pre_full(m0_rqd_pre_full),
	.i_rdy(i_m0_rqd_rdy), .o_word(o_m0_rqd), .o_wr(o_m0_rqd_wr)
);

vxe_vpu_us_queue #(.payload_t(rqd_t)) m1_rqd_q (
	.clk(clk), .nrst(nrst), .i_push(m1_rqd_push), .i_word(rqd_word),
	.o_full(m1_rqd_full), .o_pre_full(m1_rqd_pre_full),
	.i_rdy(i_m1_rqd_rdy), .o_word(o_m1_rqd), .o_wr(o_m1_rqd_wr)
);

/* The ingress stall margin must keep every push off a full queue */
a_no_push_full: assert property (@(posedge clk) disable iff (!nrst)
	!((m0_rqa_push && m0_rqa_full) || (m1_rqa_push && m1_rqa_full) ||
	(m0_rqd_push && m0_rqd_full) || (m1_rqd_push && m1_rqd_full)));

endmodule

// File: test/vxe_vpu_us_model.svh
/*
 * Request model of the VPU upstream path, included inside the testbench
 * Ports 0 and 1 are the address ports of master 0 and 1, 2 and 3 the data
 * ports, and address words are kept zero-extended to RQD_W
 */
`ifndef VXE_VPU_US_MODEL_SVH
`define VXE_VPU_US_MODEL_SVH

rqa_t	drv_rqa_q[$];	/* Address words still to be driven */
rqd_t	drv_rqd_q[$];	/* Write data still to be driven */
rqd_t	exp_q[4][$];	/* Expected words per master port */

/* Loads follow the argument bit, stores keep only VPU0 on master 0 */
function automatic logic route_of(input logic rnw, input logic [CLIENT_W-1:0] client,
	input logic arg);
	if(rnw)
		return arg;
	return (client != CLNT_VPU0);
endfunction

/* One random request, read_pct is the chance of a read in percent */
task automatic gen_request(input int read_pct);
	logic			rnw;
	logic [CLIENT_W-1:0]	client;
	logic			arg;
	logic			dst;
	rqa_t			word;
	rqd_t			data;
	rnw = ($urandom_range(99) < read_pct);
	client = CLIENT_W'($urandom);	/* Codes 2 and 3 count as other clients */
	arg = 1'($urandom);
	data = RQD_W'({$urandom, $urandom, $urandom});
	word = '0;
	word[RQA_ADDR_LSB +: ADDR_W] = ADDR_W'({$urandom, $urandom});
	word[RQA_RNW_BIT] = rnw;
	word[RQA_TXNID_LSB + TXN_CLIENT_LSB +: CLIENT_W] = client;
	word[RQA_TXNID_LSB + TXN_THREAD_LSB +: THREAD_W] = THREAD_W'($urandom);
	word[RQA_TXNID_LSB + TXN_ARG_BIT] = arg;
	dst = route_of(rnw, client, arg);
	drv_rqa_q.push_back(word);
	exp_q[dst].push_back(RQD_W'(word));
	if(!rnw)
	begin
		drv_rqd_q.push_back(data);
		exp_q[2 + dst].push_back(data);	/* Data follows its address */
	end
endtask

/* Words the DUT still owes on all four ports */
function automatic int exp_left();
	return exp_q[0].size() + exp_q[1].size() + exp_q[2].size() + exp_q[3].size();
endfunction

`endif

// File: test/tb_vxe_mem_hub_vpu_us.sv
`timescale 1ns/100ps

/*
 * Testbench of the VPU upstream request path
 * Random requests and random master ready come from seed 32'h26cf
 * Write data is never offered after its write address, as the DUT needs
 * The run is cut off at 40 cycles per generated request
 */

module tb_vxe_mem_hub_vpu_us
	import vxe_vpu_us_pkg::*;
();

/* ============================== */
/* Run length                     */
/* ============================== */
localparam int N_READS = 16;
localparam int N_WRITES = 16;
localparam int N_EARLY = 8;	/* Groups of three reads and one write */
localparam int N_RANDOM = 160;
localparam int N_REQ = N_READS + N_WRITES + 4 * N_EARLY + N_RANDOM;
localparam int CYC_LIMIT = 40 * N_REQ;
localparam int EARLY_MIX = -1;	/* Read chance code for the early data pattern */

logic		clk = 1'b0;
logic		nrst = 1'b0;
logic		i_rqa_vld = 1'b0;
rqa_t		i_rqa = '0;
logic		o_rqa_rd;
logic		i_rqd_vld = 1'b0;
rqd_t		i_rqd = '0;
logic		o_rqd_rd;
logic [3:0]	rdy = '1;	/* Order is m0 rqa, m1 rqa, m0 rqd, m1 rqd */
rqa_t		o_m0_rqa, o_m1_rqa;
rqd_t		o_m0_rqd, o_m1_rqd;
logic		o_m0_rqa_wr, o_m1_rqa_wr, o_m0_rqd_wr, o_m1_rqd_wr;
string		test_name = "after_reset";
int		rdy_pct = 100;	/* Chance of rdy per port and cycle */
int		addr_pct = 100;	/* Chance an idle address channel gets a word */
int		n_mismatch = 0;
int		n_port = 0;	/* Lost, extra or unstable words */
int		n_reset = 0;
int		cycles = 0;
int		rqd_shown = 0;	/* Data words offered so far */
int		rqd_shown_s = 0;	/* Same, as seen at the last falling edge */
int		n_wr_addr = 0;	/* Write addresses offered so far */
logic		rqa_fire = 1'b0;	/* Address word is taken at the coming edge */
logic		rqd_fire = 1'b0;
logic [3:0]	held = '0;	/* Port offered a word that was not taken */
rqd_t		prev_word [4];

`include "vxe_vpu_us_model.svh"

always #5 clk = ~clk;

vxe_mem_hub_vpu_us vxe_mem_hub_vpu_us_i (
	.clk(clk), .nrst(nrst),
	.i_rqa_vld(i_rqa_vld), .i_rqa(i_rqa), .o_rqa_rd(o_rqa_rd),
	.i_rqd_vld(i_rqd_vld), .i_rqd(i_rqd), .o_rqd_rd(o_rqd_rd),
	.i_m0_rqa_rdy(rdy[0]), .o_m0_rqa(o_m0_rqa), .o_m0_rqa_wr(o_m0_rqa_wr),
	.i_m0_rqd_rdy(rdy[2]), .o_m0_rqd(o_m0_rqd), .o_m0_rqd_wr(o_m0_rqd_wr),
	.i_m1_rqa_rdy(rdy[1]), .o_m1_rqa(o_m1_rqa), .o_m1_rqa_wr(o_m1_rqa_wr),
	.i_m1_rqd_rdy(rdy[3]), .o_m1_rqd(o_m1_rqd), .o_m1_rqd_wr(o_m1_rqd_wr)
);

/* ============================== */
/* Checking                       */
/* ============================== */
/* Hold and order check of one master port at the falling edge */
task automatic check_port(input int p, input logic wr, input rqd_t word);
	rqd_t	exp;
	if(held[p])
		assert(wr && word == prev_word[p]) else
		begin
			n_port++;
			$display("Port %0d dropped wr or changed its word under low rdy in %s", p, test_name);
		end
	held[p] = wr && !rdy[p];
	prev_word[p] = word;
	if(wr && rdy[p])	/* Accepted at the coming edge */
	begin
		assert(exp_q[p].size() != 0) else
		begin
			n_port++;
			$display("Port %0d delivered a word that was never requested in %s", p, test_name);
		end
		if(exp_q[p].size() != 0)
		begin
			exp = exp_q[p].pop_front();
			assert(word == exp) else
			begin
				n_mismatch++;
				$display("MISMATCH %s port %0d expected %h actual %h", test_name, p, exp, word);
			end
		end
	end
endtask

/* Inputs change 1 ns after the rising edge, so this edge sees settled values */
always @(negedge clk)
begin
	rqa_fire = i_rqa_vld && o_rqa_rd;
	rqd_fire = i_rqd_vld && o_rqd_rd;
	rqd_shown_s = rqd_shown;
	if(nrst)
	begin
		check_port(0, o_m0_rqa_wr, RQD_W'(o_m0_rqa));
		check_port(1, o_m1_rqa_wr, RQD_W'(o_m1_rqa));
		check_port(2, o_m0_rqd_wr, o_m0_rqd);
		check_port(3, o_m1_rqd_wr, o_m1_rqd);
	end
end

task automatic report_counts();
	$display("Errors: %0d mismatches, %0d port failures, %0d reset failures",
		n_mismatch, n_port, n_reset);
endtask

/* ============================== */
/* Drivers                        */
/* ============================== */
always @(posedge clk)
begin
	#1;
	if(rqa_fire)
		i_rqa_vld = 1'b0;	/* Taken at this edge */
	if(!i_rqa_vld && drv_rqa_q.size() != 0 && $urandom_range(99) < addr_pct)
	begin
		/* A write waits until its data is offered or already held */
		if(drv_rqa_q[0][RQA_RNW_BIT] || rqd_shown_s > n_wr_addr)
		begin
			i_rqa = drv_rqa_q.pop_front();
			i_rqa_vld = 1'b1;
			if(!i_rqa[RQA_RNW_BIT])
				n_wr_addr++;
		end
	end
end

/* Data runs ahead of the addresses whenever the DUT lets it */
always @(posedge clk)
begin
	#1;
	if(rqd_fire)
		i_rqd_vld = 1'b0;
	if(!i_rqd_vld && drv_rqd_q.size() != 0)
	begin
		i_rqd = drv_rqd_q.pop_front();
		i_rqd_vld = 1'b1;
		rqd_shown++;
	end
end

always @(posedge clk)
begin
	#1;
	for(int i = 0; i < 4; i++)
		rdy[i] = ($urandom_range(99) < rdy_pct);
end

/* ============================== */
/* Sequence and timeout           */
/* ============================== */
task automatic run_phase(input string name, input int n, input int read_pct,
	input int rdy_p, input int addr_p);
	int	i;
	test_name = name;
	rdy_pct = rdy_p;
	addr_pct = addr_p;
	for(i = 0; i < n; i++)
	begin
		if(read_pct == EARLY_MIX)
		begin
			repeat(3) gen_request(100);	/* Reads queue up ahead of the write */
			gen_request(0);
		end
		else
			gen_request(read_pct);
	end
	while(exp_left() != 0)
		@(posedge clk);
	repeat(4) @(posedge clk);
endtask

initial
begin
	void'($urandom(32'h26cf));
	repeat(4) @(posedge clk);
	#1;
	nrst = 1'b1;
	repeat(3)
	begin
		@(negedge clk);
		assert(!(o_m0_rqa_wr || o_m1_rqa_wr || o_m0_rqd_wr || o_m1_rqd_wr)) else
		begin
			n_reset++;
			$display("A master wr output went high with no request after reset");
		end
	end
	assert(o_rqa_rd && o_rqd_rd) else
	begin
		n_reset++;
		$display("The read strobes did not rise after reset");
	end
	run_phase("reads", N_READS, 100, 100, 60);
	run_phase("writes", N_WRITES, 0, 100, 60);
	run_phase("early_data", N_EARLY, EARLY_MIX, 100, 25);
	run_phase("backpressure", N_RANDOM, 50, 50, 80);
	report_counts();
	if(n_mismatch + n_port + n_reset == 0)
		$display("RESULT: PASS");
	else
		$display("RESULT: FAIL");
	$finish;
end

always @(posedge clk)
begin
	cycles++;
	if(cycles >= CYC_LIMIT)
	begin
		$display("Timeout in %s after %0d cycles, words never delivered: %0d %0d %0d %0d",
			test_name, cycles, exp_q[0].size(), exp_q[1].size(),
			exp_q[2].size(), exp_q[3].size());
		report_counts();
		$display("RESULT: FAIL");
		$finish;
	end
end

endmodule

// File: vxe_mem_hub_vpu_us.f
+incdir+test
hw/vxe_vpu_us_pkg.sv
hw/vxe_vpu_us_decode.sv
hw/vxe_vpu_us_rx.sv
hw/vxe_vpu_us_queue.sv
hw/vxe_mem_hub_vpu_us.sv
test/tb_vxe_mem_hub_vpu_us.sv

// File: Makefile
# Verilator build and run of the VPU upstream path testbench

TOP := tb_vxe_mem_hub_vpu_us
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG) for a pass"
	@echo "  clean  remove the build folder and $(LOG)"

obj_dir/V$(TOP): vxe_mem_hub_vpu_us.f $(wildcard hw/*.sv test/*.sv test/*.svh)
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f vxe_mem_hub_vpu_us.f

test: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
